/* tb.f */
source/axi_mem_pkg.sv
source/axi_mem_addr_gen.sv
source/axi_mem_store.sv
source/axi_mem_ctrl.sv
source/axi_mem_top.sv
testbench/axi_mem_tb.sv

/* Bender.yml */
package:
  name: axi_mem

dependencies: {}

sources:
  # RTL in compile order.
  - files:
      - source/axi_mem_pkg.sv
      - source/axi_mem_addr_gen.sv
      - source/axi_mem_store.sv
      - source/axi_mem_ctrl.sv
      - source/axi_mem_top.sv

  # Testbench, top module axi_mem_tb.
  - target: test
    files:
      - testbench/axi_mem_tb.sv

/* testbench/axi_mem_tb.sv */
// Testbench for the AXI4 memory slave.
// Directed bursts checked against a byte-level reference memory.

module axi_mem_tb
  import axi_mem_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 64; // Cycles before a handshake wait gives up.

  logic       clk;
  logic       reset;
  axi_addr_s  aw;
  logic       awvalid;
  logic       awready;
  axi_wbeat_s w;
  logic       wvalid;
  logic       wready;
  axi_bresp_s b;
  logic       bvalid;
  logic       bready;
  axi_addr_s  ar;
  logic       arvalid;
  logic       arready;
  axi_rbeat_s r;
  logic       rvalid;
  logic       rready;

  // Byte-level model of the store contents.
  logic [7:0] ref_bytes   [MEM_ELS*STRB_WIDTH];
  logic       ref_written [MEM_ELS*STRB_WIDTH];

  logic [DATA_WIDTH-1:0] wr_data [BURST_LEN];
  logic [STRB_WIDTH-1:0] wr_strb [BURST_LEN];
  logic [DATA_WIDTH-1:0] rd_got  [BURST_LEN]; // Data of the latest read burst.

  axi_mem_top UUT (
    .clk_i(clk), .reset_i(reset),
    .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
    .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
    .b_o(b), .bvalid_o(bvalid), .bready_i(bready),
    .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
    .r_o(r), .rvalid_o(rvalid), .rready_i(rready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Stopping at the first error.");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual));
    end
  endtask

  task automatic count_wait(inout int cycles, input string what);
    cycles++;
    if (cycles > WAIT_LIMIT) begin
      abort_run($sformatf("Timed out after %0d cycles waiting for %s.", WAIT_LIMIT, what));
    end
  endtask

  // Only the bits above the byte offset select a word, and they wrap at MEM_ELS.
  function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr, input int beat);
    return int'(((addr / STRB_WIDTH) + ADDR_WIDTH'(beat)) % MEM_ELS);
  endfunction

  function automatic void ref_write(input int idx, input logic [DATA_WIDTH-1:0] data,
                                    input logic [STRB_WIDTH-1:0] strb);
    for (int k = 0; k < STRB_WIDTH; k++) begin
      if (strb[k]) begin
        ref_bytes[idx*STRB_WIDTH + k]   = data[k*8 +: 8];
        ref_written[idx*STRB_WIDTH + k] = 1'b1;
      end
    end
  endfunction

  function automatic logic [DATA_WIDTH-1:0] expected_word(input int idx);
    logic [DATA_WIDTH-1:0] word;
    for (int k = 0; k < STRB_WIDTH; k++) begin
      word[k*8 +: 8] = ref_written[idx*STRB_WIDTH + k] ? ref_bytes[idx*STRB_WIDTH + k]
                                                       : UNINIT_WORD[k*8 +: 8];
    end
    return word;
  endfunction

  task automatic fill_beats(input bit full_strobe);
    for (int i = 0; i < BURST_LEN; i++) begin
      wr_data[i] = {$urandom, $urandom};
      wr_strb[i] = full_strobe ? {STRB_WIDTH{1'b1}} : STRB_WIDTH'($urandom);
    end
  endtask

  task automatic write_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                             input int beats, input int max_gap, input int b_stall);
    int cycles;
    axi_bresp_s held;
    @(negedge clk);
    aw = '{id: id, addr: addr};
    awvalid = 1'b1;
    cycles = 0;
    while (!awready) begin
      @(negedge clk);
      count_wait(cycles, "the write address handshake");
    end
    @(negedge clk);
    awvalid = 1'b0;
    check_value("wready_o", 1, wready); // Data phase opens after AW.
    for (int i = 0; i < beats; i++) begin
      wvalid = 1'b0;
      repeat ($urandom_range(0, max_gap)) @(negedge clk);
      w = '{data: wr_data[i], strb: wr_strb[i], last: (i == beats - 1)};
      wvalid = 1'b1;
      cycles = 0;
      while (!wready) begin
        @(negedge clk);
        count_wait(cycles, "a write data handshake");
      end
      check_value("awready_o", 0, awready);
      ref_write(word_index(addr, i), wr_data[i], wr_strb[i]);
      @(negedge clk);
    end
    wvalid = 1'b0;
    w.last = 1'b0;
    check_value("wready_o", 0, wready);
    check_value("bvalid_o", 1, bvalid); // One cycle after the last beat.
    check_value("b_o.id", id, b.id);
    check_value("b_o.resp", 0, b.resp);
    held = b;
    repeat (b_stall) begin
      @(negedge clk);
      check_value("bvalid_o", 1, bvalid);
      check_value("b_o", held, b);
      check_value("awready_o", 0, awready);
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    check_value("bvalid_o", 0, bvalid);
    check_value("awready_o", 1, awready);
  endtask

  task automatic read_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                            input int max_stall);
    int cycles;
    axi_rbeat_s held;
    @(negedge clk);
    ar = '{id: id, addr: addr};
    arvalid = 1'b1;
    cycles = 0;
    while (!arready) begin
      @(negedge clk);
      count_wait(cycles, "the read address handshake");
    end
    @(negedge clk);
    arvalid = 1'b0;
    check_value("rvalid_o", 1, rvalid); // Beat 0 follows AR directly.
    for (int i = 0; i < BURST_LEN; i++) begin
      cycles = 0;
      while (!rvalid) begin
        @(negedge clk);
        count_wait(cycles, "a read data beat");
      end
      check_value("r_o.data", expected_word(word_index(addr, i)), r.data);
      check_value("r_o.id", id, r.id);
      check_value("r_o.resp", 0, r.resp);
      check_value("r_o.last", i == BURST_LEN - 1, r.last);
      rd_got[i] = r.data;
      held = r;
      rready = 1'b0;
      repeat ($urandom_range(0, max_stall)) begin
        @(negedge clk);
        check_value("rvalid_o", 1, rvalid);
        check_value("r_o", held, r);
      end
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
    end
    check_value("arready_o", 1, arready);
    check_value("rvalid_o", 0, rvalid);
  endtask

  task automatic test_reset_state();
    check_value("awready_o", 1, awready);
    check_value("arready_o", 1, arready);
    check_value("wready_o", 0, wready);
    check_value("bvalid_o", 0, bvalid);
    check_value("rvalid_o", 0, rvalid);
    read_burst(4'h1, 32'h0000_0400, 0);
    check_value("r_o.data", UNINIT_WORD, rd_got[0]);
  endtask

  task automatic test_full_write_read();
    fill_beats(1'b1);
    write_burst(4'h3, 32'h0000_0100, BURST_LEN, 0, 0);
    read_burst(4'h5, 32'h0000_0100, 0);
    for (int i = 0; i < BURST_LEN; i++) begin
      check_value("r_o.data", wr_data[i], rd_got[i]);
    end
  endtask

  // Words 28 to 40 overlap the burst written by the full-strobe test.
  task automatic test_partial_strobes();
    int word;
    for (int t = 0; t < 8; t++) begin
      word = $urandom_range(28, 40);
      fill_beats(1'b0);
      write_burst(ID_WIDTH'(t), ADDR_WIDTH'(word * STRB_WIDTH),
                  $urandom_range(1, BURST_LEN), 1, 0);
      read_burst(ID_WIDTH'(t + 8), ADDR_WIDTH'(word * STRB_WIDTH), 1);
    end
  endtask

  task automatic test_aliasing();
    fill_beats(1'b1);
    write_burst(4'h7, 32'h0000_0200 + MEM_ELS * STRB_WIDTH, 1, 0, 0);
    read_burst(4'h8, 32'h0000_0200, 0);
    check_value("r_o.data", wr_data[0], rd_got[0]);
  endtask

  task automatic test_back_pressure();
    fill_beats(1'b0);
    write_burst(4'h9, 32'h0000_0300, BURST_LEN, 2, $urandom_range(3, 8));
    read_burst(4'ha, 32'h0000_0300, 4);
  endtask

  task automatic test_independence();
    fill_beats(1'b1);
    fork
      write_burst(4'hb, 32'h0000_0600, BURST_LEN, 2, 2);
      read_burst(4'hc, 32'h0000_0100, 3);
    join
    read_burst(4'hd, 32'h0000_0600, 0);
    for (int i = 0; i < BURST_LEN; i++) begin
      check_value("r_o.data", wr_data[i], rd_got[i]);
    end
  endtask

  initial begin
    void'($urandom(32'haa0112e2));
    reset = 1'b1;
    aw = '0;
    awvalid = 1'b0;
    w = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    ar = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    for (int i = 0; i < MEM_ELS * STRB_WIDTH; i++) begin
      ref_bytes[i]   = 8'h00;
      ref_written[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_full_write_read();
    test_partial_strobes();
    test_aliasing();
    test_back_pressure();
    test_independence();
    $display("Regression passed");
    $finish;
  end

endmodule

/* source/axi_mem_top.sv */
// AXI4 memory slave standing in for DRAM in a test harness.
// Independent write and read halves, one burst at a time on each.

module axi_mem_top
  import axi_mem_pkg::*;
#(
  parameter bit dram_enabled_p = 1'b1
) (
  input  logic       clk_i,
  input  logic       reset_i,

  input  axi_addr_s  aw_i,
  input  logic       awvalid_i,
  output logic       awready_o,

  input  axi_wbeat_s w_i,
  input  logic       wvalid_i,
  output logic       wready_o,

  output axi_bresp_s b_o,
  output logic       bvalid_o,
  input  logic       bready_i,

  input  axi_addr_s  ar_i,
  input  logic       arvalid_i,
  output logic       arready_o,

  output axi_rbeat_s r_o,
  output logic       rvalid_o,
  input  logic       rready_i
);

  logic wr_load, wr_step, rd_load, rd_step, mem_we;
  logic rd_last, rlast;
  logic [ID_WIDTH-1:0]   wr_id, rd_id;
  logic [IDX_WIDTH-1:0]  wr_idx, rd_idx;
  logic [DATA_WIDTH-1:0] rdata;

  axi_mem_ctrl #(
    .dram_enabled_p(dram_enabled_p)
  ) ctrl (
    .clk_i, .reset_i,
    .awvalid_i, .awready_o,
    .wvalid_i, .wlast_i(w_i.last), .wready_o,
    .bvalid_o, .bready_i,
    .arvalid_i, .arready_o,
    .rvalid_o, .rlast_o(rlast), .rready_i, .rd_last_i(rd_last),
    .wr_load_o(wr_load), .wr_step_o(wr_step),
    .rd_load_o(rd_load), .rd_step_o(rd_step),
    .mem_we_o(mem_we)
  );

  // Write bursts are ended by wlast, so this generator's last flag goes unused.
  axi_mem_addr_gen wr_addr (
    .clk_i, .reset_i, .load_i(wr_load), .step_i(wr_step), .req_i(aw_i),
    .id_o(wr_id), .idx_o(wr_idx), .last_o()
  );

  axi_mem_addr_gen rd_addr (
    .clk_i, .reset_i, .load_i(rd_load), .step_i(rd_step), .req_i(ar_i),
    .id_o(rd_id), .idx_o(rd_idx), .last_o(rd_last)
  );

  axi_mem_store store (
    .clk_i, .reset_i, .we_i(mem_we), .wr_idx_i(wr_idx), .rd_idx_i(rd_idx),
    .wbeat_i(w_i), .rdata_o(rdata)
  );

  assign b_o = '{id: wr_id, resp: 2'b00};
  assign r_o = '{id: rd_id, data: rdata, resp: 2'b00, last: rlast};

endmodule

/* source/axi_mem_ctrl.sv */
// Channel control for the AXI4 memory slave.
// Write and read FSMs produce the handshakes and the datapath enables.

module axi_mem_ctrl
  import axi_mem_pkg::*;
#(
  parameter bit dram_enabled_p = 1'b1
) (
  input  logic clk_i,
  input  logic reset_i,

  input  logic awvalid_i,
  output logic awready_o,
  input  logic wvalid_i,
  input  logic wlast_i,
  output logic wready_o,
  output logic bvalid_o,
  input  logic bready_i,

  input  logic arvalid_i,
  output logic arready_o,
  output logic rvalid_o,
  output logic rlast_o,
  input  logic rready_i,
  input  logic rd_last_i, // Read generator is on its final beat.

  output logic wr_load_o,
  output logic wr_step_o,
  output logic rd_load_o,
  output logic rd_step_o,
  output logic mem_we_o
);

  wr_state_e wr_state_r, wr_state_n;
  rd_state_e rd_state_r, rd_state_n;

  // Handshake outputs depend on the current state alone.
  assign awready_o = (wr_state_r == WR_WAIT_ADDR);
  assign wready_o  = (wr_state_r == WR_WAIT_DATA);
  assign bvalid_o  = (wr_state_r == WR_RESP);

  assign arready_o = (rd_state_r == RD_WAIT_ADDR);
  assign rvalid_o  = (rd_state_r == RD_SEND_DATA);
  assign rlast_o   = rvalid_o & rd_last_i;

  assign wr_load_o = awvalid_i & awready_o;
  assign wr_step_o = wvalid_i & wready_o; // One word per accepted beat.
  assign mem_we_o  = wr_step_o;

  assign rd_load_o = arvalid_i & arready_o;
  assign rd_step_o = rvalid_o & rready_i;

  always_comb begin
    wr_state_n = wr_state_r;
    case (wr_state_r)
      WR_WAIT_ADDR: begin
        if (wr_load_o) wr_state_n = WR_WAIT_DATA;
      end
      WR_WAIT_DATA: begin
        if (wr_step_o && wlast_i) wr_state_n = WR_RESP;
      end
      WR_RESP: begin
        if (bready_i) wr_state_n = WR_WAIT_ADDR; // Response held until taken.
      end
      default: wr_state_n = WR_WAIT_ADDR;
    endcase
  end

  always_comb begin
    rd_state_n = rd_state_r;
    case (rd_state_r)
      RD_WAIT_ADDR: begin
        if (rd_load_o) rd_state_n = RD_SEND_DATA;
      end
      RD_SEND_DATA: begin
        if (rd_step_o && rd_last_i) rd_state_n = RD_WAIT_ADDR;
      end
      default: rd_state_n = RD_WAIT_ADDR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_r <= WR_WAIT_ADDR;
      rd_state_r <= RD_WAIT_ADDR;
    end else begin
      wr_state_r <= wr_state_n;
      rd_state_r <= rd_state_n;
    end
  end

  // A harness built without DRAM must never issue a request.
  no_dram_request_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !dram_enabled_p |-> !(awvalid_i || arvalid_i)
  ) else $error("Memory request seen while DRAM is disabled.");

  // The store is only written while the write FSM collects data.
  we_in_data_state_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_we_o |-> (wr_state_r == WR_WAIT_DATA)
  ) else $error("Store write outside the data phase.");

endmodule

/* source/axi_mem_store.sv */
// Word store for the AXI4 memory slave.
// Strobed byte writes, per-byte written flags, and a read port that
// returns the fill pattern for bytes never written.

module axi_mem_store
  import axi_mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  we_i,
  input  logic [IDX_WIDTH-1:0]  wr_idx_i,
  input  logic [IDX_WIDTH-1:0]  rd_idx_i,
  input  axi_wbeat_s            wbeat_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic [DATA_WIDTH-1:0] mem_q [MEM_ELS];
  logic [MEM_ELS-1:0][STRB_WIDTH-1:0] written_q;

  logic [DATA_WIDTH-1:0] rd_word;
  logic [STRB_WIDTH-1:0] rd_flags;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int k = 0; k < STRB_WIDTH; k++) begin
        if (wbeat_i.strb[k]) begin
          mem_q[wr_idx_i][k*8 +: 8] <= wbeat_i.data[k*8 +: 8];
        end
      end
    end
  end

  // Flags mark which bytes hold real data.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      written_q <= '0;
    end else if (we_i) begin
      written_q[wr_idx_i] <= written_q[wr_idx_i] | wbeat_i.strb;
    end
  end

  assign rd_word  = mem_q[rd_idx_i];
  assign rd_flags = written_q[rd_idx_i];

  always_comb begin
    for (int k = 0; k < STRB_WIDTH; k++) begin
      rdata_o[k*8 +: 8] = rd_flags[k] ? rd_word[k*8 +: 8] // Byte was written.
                                      : UNINIT_WORD[k*8 +: 8];
    end
  end

endmodule

/* source/axi_mem_addr_gen.sv */
// Burst address generator.
// Holds the request ID and word address and counts beats within a burst.

module axi_mem_addr_gen
  import axi_mem_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 load_i,
  input  logic                 step_i,
  input  axi_addr_s            req_i,
  output logic [ID_WIDTH-1:0]  id_o,
  output logic [IDX_WIDTH-1:0] idx_o,
  output logic                 last_o
);

  logic [ID_WIDTH-1:0]   id_r;
  logic [ADDR_WIDTH-1:0] addr_r;
  logic [BEAT_WIDTH-1:0] beat_r;

  // Counts accepted beats since the last load.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_r <= '0;
    end else if (load_i) begin
      beat_r <= '0;
    end else if (step_i) begin
      beat_r <= beat_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      id_r   <= req_i.id;
      addr_r <= req_i.addr;
    end else if (step_i) begin
      addr_r <= addr_r + ADDR_WIDTH'(STRB_WIDTH); // Next word.
    end
  end

  assign id_o   = id_r;
  assign idx_o  = addr_r[BYTE_OFFSET +: IDX_WIDTH];
  assign last_o = (beat_r == BEAT_WIDTH'(BURST_LEN - 1));

  // Address load and step come from different FSM states.
  load_step_exclusive_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(load_i && step_i)
  ) else $error("Address generator loaded and stepped together.");

endmodule

/* source/axi_mem_pkg.sv */
// Shared definitions for the AXI4 memory slave.
// Widths, burst geometry, fill pattern, channel structs and FSM states.

package axi_mem_pkg;

  localparam int ID_WIDTH    = 4;
  localparam int ADDR_WIDTH  = 32;
  localparam int DATA_WIDTH  = 64;
  localparam int STRB_WIDTH  = DATA_WIDTH / 8;
  localparam int BYTE_OFFSET = 3; // log2 of STRB_WIDTH.

  // Word index sits directly above the byte offset, so upper address bits alias.
  localparam int MEM_ELS   = 256;
  localparam int IDX_WIDTH = 8;

  localparam int BURST_LEN  = 4;
  localparam int BEAT_WIDTH = 2;

  // Returned for any byte that has not been written since reset.
  localparam logic [DATA_WIDTH-1:0] UNINIT_WORD = {2{32'hdead_beef}};

  // AW and AR request, also the load value of an address generator.
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
  } axi_addr_s;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } axi_wbeat_s;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp; // Always OKAY.
    logic                  last;
  } axi_rbeat_s;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [1:0]          resp;
  } axi_bresp_s;

  typedef enum logic [1:0] {
    WR_WAIT_ADDR,
    WR_WAIT_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_WAIT_ADDR,
    RD_SEND_DATA
  } rd_state_e;

endpackage
